// ==== src/rvIsaPkg.sv ====
// RV32I encodings needed by the control path, no compressed or system opcodes
// ALU operation codes must match the datapath ALU
`default_nettype none

package rvIsaPkg;

    // raw instruction fields
    typedef logic [6:0] opcodeT;
    typedef logic [2:0] funct3T;

    // ALU operation, shared with the datapath ALU
    typedef enum logic [2:0]
    {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluXor = 3'b100,
        aluSlt = 3'b101
    } aluCtrlT;

    // immediate format for the extend unit
    typedef enum logic [2:0]
    {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100
    } immSrcT;

    // opcodes handled by the controller
    localparam opcodeT OP_LOAD   = 7'b0000011;
    localparam opcodeT OP_STORE  = 7'b0100011;
    localparam opcodeT OP_RTYPE  = 7'b0110011;
    localparam opcodeT OP_ITYPE  = 7'b0010011;
    localparam opcodeT OP_JAL    = 7'b1101111;
    localparam opcodeT OP_BRANCH = 7'b1100011;
    localparam opcodeT OP_LUI    = 7'b0110111;
    // all-zero word treated as nop
    localparam opcodeT OP_NOP    = 7'b0000000;

    // funct3 values of the arithmetic group
    localparam funct3T F3_ADD_SUB = 3'b000;
    localparam funct3T F3_SLT     = 3'b010;
    localparam funct3T F3_XOR     = 3'b100;
    localparam funct3T F3_OR      = 3'b110;
    localparam funct3T F3_AND     = 3'b111;

endpackage

`default_nettype wire

// ==== src/ctrlPkg.sv ====
// control path types of the multicycle controller
// select encodings are fixed by the datapath muxes
`default_nettype none

package ctrlPkg;

    // multicycle FSM states, 14 of 16 codes used
    typedef enum logic [3:0]
    {
        sReset        = 4'd0,
        sFetch        = 4'd1,
        sDecode       = 4'd2,
        sMemAddr      = 4'd3,
        sMemRead      = 4'd4,
        sMemWb        = 4'd5,
        sMemWrite     = 4'd6,
        sExecuteR     = 4'd7,
        sAluWriteBack = 4'd8,
        sExecuteI     = 4'd9,
        sJal          = 4'd10,
        sBeq          = 4'd11,
        sLui          = 4'd12,
        sError        = 4'd13
    } ctrlStateT;

    // instruction class from the opcode
    typedef enum logic [3:0]
    {
        clsLoad    = 4'd0,
        clsStore   = 4'd1,
        clsRType   = 4'd2,
        clsIType   = 4'd3,
        clsJal     = 4'd4,
        clsBranch  = 4'd5,
        clsLui     = 4'd6,
        clsNop     = 4'd7,
        clsIllegal = 4'd8
    } instrClassT;

    // ALU A input mux
    typedef enum logic [1:0]
    {
        srcAPc    = 2'b00,
        srcAOldPc = 2'b01,
        srcAReg   = 2'b10,
        srcAZero  = 2'b11
    } srcASelT;

    // ALU B input mux
    typedef enum logic [1:0]
    {
        srcBReg  = 2'b00,
        srcBImm  = 2'b01,
        srcBFour = 2'b10
    } srcBSelT;

    // result bus mux
    typedef enum logic [1:0]
    {
        resAluOut    = 2'b00,
        resData      = 2'b01,
        resAluResult = 2'b10
    } resultSelT;

endpackage

`default_nettype wire

// ==== src/instrDecode.sv ====
// purely combinational, fields must be stable from Decode to the next Fetch
// unknown opcodes classify as illegal, funct7 bit 5 only matters for R-type
`timescale 1ns/1ps
`default_nettype none

module instrDecode
(
    input  rvIsaPkg::opcodeT      i_opcode,
    input  rvIsaPkg::funct3T      i_funct3,
    input  logic                  i_funct7b5,
    output ctrlPkg::instrClassT   o_instrClass,
    output rvIsaPkg::aluCtrlT     o_aluCtrl,
    output rvIsaPkg::immSrcT      o_immSrc
);

    // opcode to class and immediate format
    always_comb
    begin
        o_instrClass = ctrlPkg::clsIllegal;
        // I format also covers the classes without an immediate
        o_immSrc = rvIsaPkg::immI;
        case (i_opcode)
            rvIsaPkg::OP_LOAD:
            begin
                o_instrClass = ctrlPkg::clsLoad;
            end
            rvIsaPkg::OP_STORE:
            begin
                o_instrClass = ctrlPkg::clsStore;
                o_immSrc = rvIsaPkg::immS;
            end
            rvIsaPkg::OP_RTYPE:
            begin
                o_instrClass = ctrlPkg::clsRType;
            end
            rvIsaPkg::OP_ITYPE:
            begin
                o_instrClass = ctrlPkg::clsIType;
            end
            rvIsaPkg::OP_JAL:
            begin
                o_instrClass = ctrlPkg::clsJal;
                o_immSrc = rvIsaPkg::immJ;
            end
            rvIsaPkg::OP_BRANCH:
            begin
                o_instrClass = ctrlPkg::clsBranch;
                o_immSrc = rvIsaPkg::immB;
            end
            rvIsaPkg::OP_LUI:
            begin
                o_instrClass = ctrlPkg::clsLui;
                o_immSrc = rvIsaPkg::immU;
            end
            rvIsaPkg::OP_NOP:
            begin
                o_instrClass = ctrlPkg::clsNop;
            end
            default:
            begin
                o_instrClass = ctrlPkg::clsIllegal;
            end
        endcase
    end

    // ALU op from funct3, only for the arithmetic classes
    always_comb
    begin
        o_aluCtrl = rvIsaPkg::aluAdd;
        if (o_instrClass == ctrlPkg::clsRType || o_instrClass == ctrlPkg::clsIType)
        begin
            case (i_funct3)
                // addi has no sub form, so funct7 is ignored for I-type
                rvIsaPkg::F3_ADD_SUB:
                    o_aluCtrl = (o_instrClass == ctrlPkg::clsRType && i_funct7b5)
                              ? rvIsaPkg::aluSub : rvIsaPkg::aluAdd;
                rvIsaPkg::F3_SLT:
                    o_aluCtrl = rvIsaPkg::aluSlt;
                rvIsaPkg::F3_XOR:
                    o_aluCtrl = rvIsaPkg::aluXor;
                rvIsaPkg::F3_OR:
                    o_aluCtrl = rvIsaPkg::aluOr;
                rvIsaPkg::F3_AND:
                    o_aluCtrl = rvIsaPkg::aluAnd;
                // shifts and sltu are not supported
                default:
                    o_aluCtrl = rvIsaPkg::aluAdd;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/phaseSequencer.sv ====
// state register of the multicycle FSM, one transition per clk
// resetn is an active-high synchronous reset, held state is Reset
// MemAddr with a class other than load or store falls into Error
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer
(
    input  logic                 clk,
    input  logic                 resetn,
    input  ctrlPkg::instrClassT  i_instrClass,
    output ctrlPkg::ctrlStateT   o_state
);

    ctrlPkg::ctrlStateT state;
    ctrlPkg::ctrlStateT nextState;

    always_ff @(posedge clk)
    begin
        if (resetn)
        begin
            state <= ctrlPkg::sReset;
        end
        else
        begin
            state <= nextState;
        end
    end

    // next state
    always_comb
    begin
        nextState = ctrlPkg::sReset;
        case (state)
            ctrlPkg::sReset:
                nextState = ctrlPkg::sFetch;
            ctrlPkg::sFetch:
                nextState = ctrlPkg::sDecode;
            // class is valid from here on
            ctrlPkg::sDecode:
            begin
                case (i_instrClass)
                    ctrlPkg::clsLoad,
                    ctrlPkg::clsStore:  nextState = ctrlPkg::sMemAddr;
                    ctrlPkg::clsRType:  nextState = ctrlPkg::sExecuteR;
                    ctrlPkg::clsIType:  nextState = ctrlPkg::sExecuteI;
                    ctrlPkg::clsJal:    nextState = ctrlPkg::sJal;
                    ctrlPkg::clsBranch: nextState = ctrlPkg::sBeq;
                    ctrlPkg::clsLui:    nextState = ctrlPkg::sLui;
                    // nop retires in Decode
                    ctrlPkg::clsNop:    nextState = ctrlPkg::sFetch;
                    default:            nextState = ctrlPkg::sError;
                endcase
            end
            ctrlPkg::sMemAddr:
            begin
                if (i_instrClass == ctrlPkg::clsLoad)
                    nextState = ctrlPkg::sMemRead;
                else if (i_instrClass == ctrlPkg::clsStore)
                    nextState = ctrlPkg::sMemWrite;
                else
                    nextState = ctrlPkg::sError;
            end
            ctrlPkg::sMemRead:
                nextState = ctrlPkg::sMemWb;
            ctrlPkg::sMemWb,
            ctrlPkg::sMemWrite,
            ctrlPkg::sAluWriteBack,
            ctrlPkg::sBeq:
                nextState = ctrlPkg::sFetch;
            ctrlPkg::sExecuteR,
            ctrlPkg::sExecuteI,
            ctrlPkg::sJal:
                nextState = ctrlPkg::sAluWriteBack;
            // lui reuses the I-type execute step
            ctrlPkg::sLui:
                nextState = ctrlPkg::sExecuteI;
            // illegal instruction restarts the machine
            ctrlPkg::sError:
                nextState = ctrlPkg::sReset;
            default:
                nextState = ctrlPkg::sReset;
        endcase
    end

    assign o_state = state;

    // class must hold from Decode until the next Fetch
    classHeld: assert property (@(posedge clk) disable iff (resetn)
        !(state inside {ctrlPkg::sReset, ctrlPkg::sFetch, ctrlPkg::sDecode})
            |-> $stable(i_instrClass));

endmodule

`default_nettype wire

// ==== src/ctrlSignalGen.sv ====
// Moore outputs decoded from the current state, no registers
// PC write in BEQ follows i_zero in the same cycle
`timescale 1ns/1ps
`default_nettype none

module ctrlSignalGen
(
    input  ctrlPkg::ctrlStateT   i_state,
    input  ctrlPkg::instrClassT  i_instrClass,
    input  rvIsaPkg::aluCtrlT    i_aluCtrl,
    input  logic                 i_zero,
    output logic                 o_pcWrite,
    output logic                 o_adrSrc,
    output logic                 o_memWrite,
    output logic                 o_irWrite,
    output ctrlPkg::resultSelT   o_resultSrc,
    output rvIsaPkg::aluCtrlT    o_aluControl,
    output ctrlPkg::srcASelT     o_aluSrcA,
    output ctrlPkg::srcBSelT     o_aluSrcB,
    output logic                 o_regWrite
);

    always_comb
    begin
        // idle values, also what Reset and Error drive
        o_pcWrite    = 1'b0;
        o_adrSrc     = 1'b0;
        o_memWrite   = 1'b0;
        o_irWrite    = 1'b0;
        o_regWrite   = 1'b0;
        o_resultSrc  = ctrlPkg::resAluOut;
        o_aluControl = rvIsaPkg::aluAdd;
        o_aluSrcA    = ctrlPkg::srcAPc;
        o_aluSrcB    = ctrlPkg::srcBReg;
        case (i_state)
            // load IR and write pc + 4 back via the result bus
            ctrlPkg::sFetch:
            begin
                o_irWrite   = 1'b1;
                o_pcWrite   = 1'b1;
                o_resultSrc = ctrlPkg::resAluResult;
                o_aluSrcA   = ctrlPkg::srcAPc;
                o_aluSrcB   = ctrlPkg::srcBFour;
            end
            // oldPc + imm, branch and jump target into ALUOut
            ctrlPkg::sDecode:
            begin
                o_aluSrcA    = ctrlPkg::srcAOldPc;
                o_aluSrcB    = ctrlPkg::srcBImm;
                o_aluControl = i_aluCtrl;
            end
            // rs1 + offset
            ctrlPkg::sMemAddr:
            begin
                o_aluSrcA = ctrlPkg::srcAReg;
                o_aluSrcB = ctrlPkg::srcBImm;
            end
            // address from ALUOut
            ctrlPkg::sMemRead:
            begin
                o_adrSrc = 1'b1;
            end
            ctrlPkg::sMemWb:
            begin
                o_resultSrc = ctrlPkg::resData;
                o_regWrite  = 1'b1;
            end
            ctrlPkg::sMemWrite:
            begin
                o_adrSrc   = 1'b1;
                o_memWrite = 1'b1;
            end
            ctrlPkg::sExecuteR:
            begin
                o_aluSrcA    = ctrlPkg::srcAReg;
                o_aluSrcB    = ctrlPkg::srcBReg;
                o_aluControl = i_aluCtrl;
            end
            // ALUOut to rd
            ctrlPkg::sAluWriteBack:
            begin
                o_regWrite = 1'b1;
            end
            // lui arrives here too, 0 + U immediate
            ctrlPkg::sExecuteI:
            begin
                o_aluSrcA    = (i_instrClass == ctrlPkg::clsLui)
                             ? ctrlPkg::srcAZero : ctrlPkg::srcAReg;
                o_aluSrcB    = ctrlPkg::srcBImm;
                o_aluControl = i_aluCtrl;
            end
            // link value oldPc + 4, target already in ALUOut from Decode
            ctrlPkg::sJal:
            begin
                o_aluSrcA = ctrlPkg::srcAOldPc;
                o_aluSrcB = ctrlPkg::srcBFour;
                o_pcWrite = 1'b1;
            end
            // rs1 - rs2, taken when the ALU reports zero
            ctrlPkg::sBeq:
            begin
                o_aluSrcA    = ctrlPkg::srcAReg;
                o_aluSrcB    = ctrlPkg::srcBReg;
                o_aluControl = rvIsaPkg::aluSub;
                o_pcWrite    = i_zero;
            end
            ctrlPkg::sLui:
            begin
                o_aluSrcA = ctrlPkg::srcAZero;
                o_aluSrcB = ctrlPkg::srcBFour;
            end
            default:
            begin
                o_pcWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/multicycleControl.sv ====
// control unit of a multicycle RV32I core, outputs are Moore from the state
// resetn is active high and synchronous, opcode fields valid from Decode on
`timescale 1ns/1ps
`default_nettype none

module multicycleControl
(
    input  logic                 clk,
    input  logic                 resetn,
    input  rvIsaPkg::opcodeT     i_opcode,
    input  rvIsaPkg::funct3T     i_funct3,
    input  logic                 i_funct7b5,
    input  logic                 i_zero,
    output logic                 o_pcWrite,
    output logic                 o_adrSrc,
    output logic                 o_memWrite,
    output logic                 o_irWrite,
    output ctrlPkg::resultSelT   o_resultSrc,
    output rvIsaPkg::aluCtrlT    o_aluControl,
    output ctrlPkg::srcASelT     o_aluSrcA,
    output ctrlPkg::srcBSelT     o_aluSrcB,
    output rvIsaPkg::immSrcT     o_immSrc,
    output logic                 o_regWrite
);

    // decoded class feeds both the FSM and the output decode
    ctrlPkg::instrClassT  instrClass;
    rvIsaPkg::aluCtrlT    decodedAluCtrl;
    ctrlPkg::ctrlStateT   state;

    instrDecode instrDecode_i
    (
        .i_opcode     (i_opcode),
        .i_funct3     (i_funct3),
        .i_funct7b5   (i_funct7b5),
        .o_instrClass (instrClass),
        .o_aluCtrl    (decodedAluCtrl),
        .o_immSrc     (o_immSrc)
    );

    phaseSequencer phaseSequencer_i
    (
        .clk          (clk),
        .resetn       (resetn),
        .i_instrClass (instrClass),
        .o_state      (state)
    );

    ctrlSignalGen ctrlSignalGen_i
    (
        .i_state      (state),
        .i_instrClass (instrClass),
        .i_aluCtrl    (decodedAluCtrl),
        .i_zero       (i_zero),
        .o_pcWrite    (o_pcWrite),
        .o_adrSrc     (o_adrSrc),
        .o_memWrite   (o_memWrite),
        .o_irWrite    (o_irWrite),
        .o_resultSrc  (o_resultSrc),
        .o_aluControl (o_aluControl),
        .o_aluSrcA    (o_aluSrcA),
        .o_aluSrcB    (o_aluSrcB),
        .o_regWrite   (o_regWrite)
    );

endmodule

`default_nettype wire

// ==== bench/multicycleControlTb.sv ====
// random instruction stream checked against a cycle model of the controller
// opcode fields are redrawn at the falling edge where IR write shows, zero every cycle
// illegal opcodes are random 7-bit values, so a few land on legal ones
`timescale 1ns/1ps
`default_nettype none

module multicycleControlTb;

    localparam integer CLK_PERIOD   = 40;
    localparam integer RESET_CYCLES = 10;
    localparam integer NUM_INSTR    = 2000;
    // five cycles per instruction at worst, plus slack
    localparam integer WATCHDOG_NS  = (RESET_CYCLES + NUM_INSTR * 5 + 100) * CLK_PERIOD;

    // model state codes, bench-local numbering
    localparam logic [3:0] M_RESET    = 4'd0;
    localparam logic [3:0] M_FETCH    = 4'd1;
    localparam logic [3:0] M_DECODE   = 4'd2;
    localparam logic [3:0] M_MEMADDR  = 4'd3;
    localparam logic [3:0] M_MEMREAD  = 4'd4;
    localparam logic [3:0] M_MEMWB    = 4'd5;
    localparam logic [3:0] M_MEMWRITE = 4'd6;
    localparam logic [3:0] M_EXECR    = 4'd7;
    localparam logic [3:0] M_ALUWB    = 4'd8;
    localparam logic [3:0] M_EXECI    = 4'd9;
    localparam logic [3:0] M_JAL      = 4'd10;
    localparam logic [3:0] M_BEQ      = 4'd11;
    localparam logic [3:0] M_LUI      = 4'd12;
    localparam logic [3:0] M_ERROR    = 4'd13;

    // instruction classes
    localparam logic [3:0] C_LOAD    = 4'd0;
    localparam logic [3:0] C_STORE   = 4'd1;
    localparam logic [3:0] C_RTYPE   = 4'd2;
    localparam logic [3:0] C_ITYPE   = 4'd3;
    localparam logic [3:0] C_JAL     = 4'd4;
    localparam logic [3:0] C_BRANCH  = 4'd5;
    localparam logic [3:0] C_LUI     = 4'd6;
    localparam logic [3:0] C_NOP     = 4'd7;
    localparam logic [3:0] C_ILLEGAL = 4'd8;

    // output encodings seen on the DUT pins
    localparam logic [2:0] ALU_ADD = 3'b000;
    localparam logic [2:0] ALU_SUB = 3'b001;
    localparam logic [2:0] ALU_AND = 3'b010;
    localparam logic [2:0] ALU_OR  = 3'b011;
    localparam logic [2:0] ALU_XOR = 3'b100;
    localparam logic [2:0] ALU_SLT = 3'b101;
    localparam logic [2:0] IMM_I   = 3'b000;
    localparam logic [2:0] IMM_S   = 3'b001;
    localparam logic [2:0] IMM_B   = 3'b010;
    localparam logic [2:0] IMM_J   = 3'b011;
    localparam logic [2:0] IMM_U   = 3'b100;
    localparam logic [1:0] SA_PC    = 2'b00;
    localparam logic [1:0] SA_OLDPC = 2'b01;
    localparam logic [1:0] SA_REG   = 2'b10;
    localparam logic [1:0] SA_ZERO  = 2'b11;
    localparam logic [1:0] SB_REG  = 2'b00;
    localparam logic [1:0] SB_IMM  = 2'b01;
    localparam logic [1:0] SB_FOUR = 2'b10;
    localparam logic [1:0] RES_DATA      = 2'b01;
    localparam logic [1:0] RES_ALURESULT = 2'b10;

    logic clk = 1'b0;
    logic resetn;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic funct7b5;
    logic zero;
    logic pcWrite;
    logic adrSrc;
    logic memWrite;
    logic irWrite;
    logic [1:0] resultSrc;
    logic [2:0] aluControl;
    logic [1:0] aluSrcA;
    logic [1:0] aluSrcB;
    logic [2:0] immSrc;
    logic regWrite;

    // model and bookkeeping
    logic [3:0] mState;
    logic [3:0] lastClass;
    logic [31:0] rng;
    logic seenFetch;
    integer errors;
    integer instrCount;
    integer cycleCount;
    integer cycleNum;

    multicycleControl multicycleControl_i
    (
        .clk          (clk),
        .resetn       (resetn),
        .i_opcode     (opcode),
        .i_funct3     (funct3),
        .i_funct7b5   (funct7b5),
        .i_zero       (zero),
        .o_pcWrite    (pcWrite),
        .o_adrSrc     (adrSrc),
        .o_memWrite   (memWrite),
        .o_irWrite    (irWrite),
        .o_resultSrc  (resultSrc),
        .o_aluControl (aluControl),
        .o_aluSrcA    (aluSrcA),
        .o_aluSrcB    (aluSrcB),
        .o_immSrc     (immSrc),
        .o_regWrite   (regWrite)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [3:0] classOf(input logic [6:0] op);
        case (op)
            rvIsaPkg::OP_LOAD:   return C_LOAD;
            rvIsaPkg::OP_STORE:  return C_STORE;
            rvIsaPkg::OP_RTYPE:  return C_RTYPE;
            rvIsaPkg::OP_ITYPE:  return C_ITYPE;
            rvIsaPkg::OP_JAL:    return C_JAL;
            rvIsaPkg::OP_BRANCH: return C_BRANCH;
            rvIsaPkg::OP_LUI:    return C_LUI;
            rvIsaPkg::OP_NOP:    return C_NOP;
            default:             return C_ILLEGAL;
        endcase
    endfunction

    // funct3 rule, only arithmetic classes decode
    function automatic logic [2:0] aluFor(input logic [3:0] cls, input logic [2:0] f3,
                                          input logic f7);
        if (cls != C_RTYPE && cls != C_ITYPE)
            return ALU_ADD;
        case (f3)
            3'b000:  return (cls == C_RTYPE && f7) ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    function automatic logic [2:0] immFor(input logic [3:0] cls);
        case (cls)
            C_STORE:  return IMM_S;
            C_BRANCH: return IMM_B;
            C_JAL:    return IMM_J;
            C_LUI:    return IMM_U;
            default:  return IMM_I;
        endcase
    endfunction

    // Fetch to next Fetch, per class
    function automatic logic [7:0] cyclesFor(input logic [3:0] cls);
        case (cls)
            C_NOP:         return 8'd2;
            C_BRANCH:      return 8'd3;
            C_LOAD, C_LUI: return 8'd5;
            default:       return 8'd4;
        endcase
    endfunction

    function automatic logic [3:0] nextStateOf(input logic [3:0] st, input logic [3:0] cls);
        case (st)
            M_RESET:  return M_FETCH;
            M_FETCH:  return M_DECODE;
            M_DECODE:
                case (cls)
                    C_LOAD, C_STORE: return M_MEMADDR;
                    C_RTYPE:         return M_EXECR;
                    C_ITYPE:         return M_EXECI;
                    C_JAL:           return M_JAL;
                    C_BRANCH:        return M_BEQ;
                    C_LUI:           return M_LUI;
                    C_NOP:           return M_FETCH;
                    default:         return M_ERROR;
                endcase
            M_MEMADDR: return (cls == C_LOAD) ? M_MEMREAD : M_MEMWRITE;
            M_MEMREAD: return M_MEMWB;
            M_EXECR, M_EXECI, M_JAL: return M_ALUWB;
            M_LUI:     return M_EXECI;
            M_ERROR:   return M_RESET;
            // MemWB, MemWrite, ALUWriteBack and BEQ retire
            default:   return M_FETCH;
        endcase
    endfunction

    task automatic expectOutputs
    (
        input  logic [3:0] st,
        input  logic [3:0] cls,
        input  logic [2:0] alu,
        input  logic       z,
        output logic       pc,
        output logic       adr,
        output logic       mem,
        output logic       ir,
        output logic [1:0] res,
        output logic [2:0] op,
        output logic [1:0] sa,
        output logic [1:0] sb,
        output logic       rw
    );
        {pc, adr, mem, ir, rw} = 5'b00000;
        res = 2'b00;
        op = ALU_ADD;
        sa = SA_PC;
        sb = SB_REG;
        case (st)
            M_FETCH:    {ir, pc, res, sa, sb} = {1'b1, 1'b1, RES_ALURESULT, SA_PC, SB_FOUR};
            M_DECODE:   {sa, sb, op} = {SA_OLDPC, SB_IMM, alu};
            M_MEMADDR:  {sa, sb} = {SA_REG, SB_IMM};
            M_MEMREAD:  adr = 1'b1;
            M_MEMWB:    {res, rw} = {RES_DATA, 1'b1};
            M_MEMWRITE: {adr, mem} = 2'b11;
            M_EXECR:    {sa, sb, op} = {SA_REG, SB_REG, alu};
            M_ALUWB:    rw = 1'b1;
            // lui takes the zero A-source here
            M_EXECI:    {sa, sb, op} = {(cls == C_LUI) ? SA_ZERO : SA_REG, SB_IMM, alu};
            M_JAL:      {sa, sb, pc} = {SA_OLDPC, SB_FOUR, 1'b1};
            M_BEQ:      {sa, sb, op, pc} = {SA_REG, SB_REG, ALU_SUB, z};
            M_LUI:      {sa, sb} = {SA_ZERO, SB_FOUR};
            default:    rw = 1'b0;
        endcase
    endtask

    task automatic checkValue(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch %s expected %0h actual %0h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    // runs at the falling edge, outputs settled since the rising edge
    task automatic checkCycle();
        logic [3:0] cls;
        logic ePc;
        logic eAdr;
        logic eMem;
        logic eIr;
        logic [1:0] eRes;
        logic [2:0] eOp;
        logic [1:0] eSa;
        logic [1:0] eSb;
        logic eRw;
        cls = classOf(opcode);
        expectOutputs(mState, cls, aluFor(cls, funct3, funct7b5), zero,
                      ePc, eAdr, eMem, eIr, eRes, eOp, eSa, eSb, eRw);
        checkValue("pcWrite", 8'(ePc), 8'(pcWrite));
        checkValue("adrSrc", 8'(eAdr), 8'(adrSrc));
        checkValue("memWrite", 8'(eMem), 8'(memWrite));
        checkValue("irWrite", 8'(eIr), 8'(irWrite));
        checkValue("resultSrc", 8'(eRes), 8'(resultSrc));
        checkValue("aluControl", 8'(eOp), 8'(aluControl));
        checkValue("aluSrcA", 8'(eSa), 8'(aluSrcA));
        checkValue("aluSrcB", 8'(eSb), 8'(aluSrcB));
        checkValue("regWrite", 8'(eRw), 8'(regWrite));
        checkValue("immSrc", 8'(immFor(cls)), 8'(immSrc));
        if (memWrite === 1'b1 && regWrite === 1'b1)
        begin
            errors++;
            $display("memory write and register write high in the same cycle at %0t", $time);
        end
        if (cycleNum == RESET_CYCLES + 1 && irWrite !== 1'b1)
        begin
            errors++;
            $display("first cycle after reset is not a Fetch at %0t", $time);
        end
        // length of the previous instruction
        cycleCount++;
        if (irWrite === 1'b1)
        begin
            if (seenFetch)
                checkValue("cyclesPerInstr", cyclesFor(lastClass), 8'(cycleCount));
            cycleCount = 0;
            seenFetch = 1'b1;
            instrCount++;
        end
    endtask

    // new inputs, then step the model with what the DUT sees next edge
    task automatic driveInputs();
        logic [31:0] pick;
        rng = xorshift(rng);
        zero = rng[7];
        if (cycleNum == RESET_CYCLES)
            resetn = 1'b0;
        if (irWrite === 1'b1)
        begin
            rng = xorshift(rng);
            pick = rng % 32'd10;
            case (pick)
                0:       opcode = rvIsaPkg::OP_LOAD;
                1:       opcode = rvIsaPkg::OP_STORE;
                2:       opcode = rvIsaPkg::OP_RTYPE;
                3:       opcode = rvIsaPkg::OP_ITYPE;
                4:       opcode = rvIsaPkg::OP_JAL;
                5:       opcode = rvIsaPkg::OP_BRANCH;
                6:       opcode = rvIsaPkg::OP_LUI;
                7:       opcode = rvIsaPkg::OP_NOP;
                default: opcode = rng[22:16];
            endcase
            funct3 = rng[10:8];
            funct7b5 = rng[11];
            lastClass = classOf(opcode);
        end
        mState = resetn ? M_RESET : nextStateOf(mState, classOf(opcode));
    endtask

    initial
    begin
        resetn = 1'b1;
        opcode = 7'd0;
        funct3 = 3'd0;
        funct7b5 = 1'b0;
        zero = 1'b0;
        rng = 32'h8bb4_2640;
        // state the DUT holds after the first rising edge
        mState = M_RESET;
        lastClass = C_NOP;
        seenFetch = 1'b0;
        errors = 0;
        instrCount = 0;
        cycleCount = 0;
        cycleNum = 0;
        while (instrCount < NUM_INSTR)
        begin
            @(negedge clk);
            cycleNum++;
            checkCycle();
            driveInputs();
        end
        $display("%0d instructions, %0d errors", instrCount, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // stuck FSM guard
    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout with %0d of %0d instructions done, %0d errors", instrCount,
                 NUM_INSTR, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
src/rvIsaPkg.sv
src/ctrlPkg.sv
src/instrDecode.sv
src/phaseSequencer.sv
src/ctrlSignalGen.sv
src/multicycleControl.sv
bench/multicycleControlTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the multicycle control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module multicycleControlTb -o multicycleControlTb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/multicycleControlTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
    exit 0
fi
exit 1
